// File: src/core_cfg_pkg.sv
`default_nettype none

package core_cfg_pkg;

  // One issue slot per functional unit
  localparam int NUM_FU = 4; // FUs and slots

  // ROB ages wrap modulo 2**ROB_IDX_W
  localparam int ROB_IDX_W = 4; // ROB index width

  localparam int TAG_W = 6;   // Physical register tag
  localparam int INST_W = 32; // Instruction word

endpackage

`default_nettype wire

// File: src/rs_types_pkg.sv
`default_nettype none

package rs_types_pkg;

  // Kind of unit bound to each slot
  typedef enum logic [1:0] {
    FU_ALU    = 2'd0, // Integer ALU
    FU_MULT   = 2'd1, // Multiplier
    FU_MEM    = 2'd2, // Load/store
    FU_BRANCH = 2'd3  // Branch unit
  } fu_kind_t;

  // Entry i gives the kind of slot i
  typedef fu_kind_t [core_cfg_pkg::NUM_FU-1:0] fu_kind_list_t;

  // Two ALUs, one multiplier, one memory port and no branch unit
  localparam fu_kind_list_t FU_KINDS_DEFAULT = '{
    FU_MEM,  // Slot 3
    FU_MULT, // Slot 2
    FU_ALU,  // Slot 1
    FU_ALU   // Slot 0
  };

endpackage

`default_nettype wire

// File: src/rs_dispatch_alloc.sv
`default_nettype none

module rs_dispatch_alloc #(
  parameter int                          NUM_FU   = core_cfg_pkg::NUM_FU,
  parameter rs_types_pkg::fu_kind_list_t FU_KINDS = rs_types_pkg::FU_KINDS_DEFAULT
) (
  input  logic                   en,
  input  logic                   dispatch_en,
  input  logic                   rollback_en,
  input  rs_types_pkg::fu_kind_t disp_kind,
  input  logic [NUM_FU-1:0]      slot_free_next,
  output logic [NUM_FU-1:0]      slot_write,
  output logic                   disp_accept
);

  logic [NUM_FU-1:0] kind_match; // Slot serves the dispatched kind
  logic [NUM_FU-1:0] candidate;  // Right kind and free by next edge
  logic [NUM_FU-1:0] pick;       // Lowest candidate, one-hot
  logic              allow;      // Dispatch may proceed this cycle

  always_comb begin
    for (int i = 0; i < NUM_FU; i++) begin
      kind_match[i] = (FU_KINDS[i] == disp_kind);
    end
  end

  assign candidate = kind_match & slot_free_next;

  // Priority pick, slot 0 first
  always_comb begin
    logic found;
    found = 1'b0;
    pick  = '0;
    for (int i = 0; i < NUM_FU; i++) begin
      if (candidate[i] && !found) begin
        pick[i] = 1'b1;
        found   = 1'b1;
      end
    end
  end

  // No dispatch during a rollback or a hold
  assign allow = dispatch_en && en && !rollback_en;

  assign slot_write  = allow ? pick : '0;
  assign disp_accept = |slot_write; // Lost if no slot of that kind frees

endmodule

`default_nettype wire

// File: src/rs_slot.sv
`default_nettype none

module rs_slot #(
  parameter rs_types_pkg::fu_kind_t KIND      = rs_types_pkg::FU_ALU,
  parameter int                     ROB_IDX_W = core_cfg_pkg::ROB_IDX_W,
  parameter int                     TAG_W     = core_cfg_pkg::TAG_W
) (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            en,
  input  logic                            write,
  input  rs_types_pkg::fu_kind_t          disp_kind,
  input  logic [core_cfg_pkg::INST_W-1:0] disp_inst,
  input  logic [ROB_IDX_W-1:0]            disp_rob_idx,
  input  logic [TAG_W-1:0]                disp_dest_tag,
  input  logic [TAG_W-1:0]                disp_src1_tag,
  input  logic                            disp_src1_ready,
  input  logic [TAG_W-1:0]                disp_src2_tag,
  input  logic                            disp_src2_ready,
  input  logic                            cdb_en,
  input  logic [TAG_W-1:0]                cdb_tag,
  input  logic                            rollback_en,
  input  logic [ROB_IDX_W-1:0]            rollback_idx,
  input  logic [ROB_IDX_W-1:0]            rob_tail_idx,
  input  logic                            grant,
  output logic                            req,
  output logic                            free_next,
  output logic [core_cfg_pkg::INST_W-1:0] entry_inst,
  output logic [ROB_IDX_W-1:0]            entry_rob_idx,
  output logic [TAG_W-1:0]                entry_dest_tag,
  output logic [TAG_W-1:0]                entry_src1_tag,
  output logic [TAG_W-1:0]                entry_src2_tag
);

  logic                 busy;
  logic                 src1_ready;
  logic                 src2_ready;
  logic                 src1_ok;    // Ready now, CDB included
  logic                 src2_ok;
  logic                 in1_ready;  // Incoming source, CDB included
  logic                 in2_ready;
  logic [ROB_IDX_W-1:0] tail_dist;
  logic [ROB_IDX_W-1:0] entry_dist;
  logic                 squash;
  logic                 load;
  logic                 take;       // Entry moves to the issue register

  assign load = write && (disp_kind == KIND); // Allocator already matched kind

  assign src1_ok = src1_ready || (cdb_en && (cdb_tag == entry_src1_tag));
  assign src2_ok = src2_ready || (cdb_en && (cdb_tag == entry_src2_tag));

  assign in1_ready = disp_src1_ready || (cdb_en && (cdb_tag == disp_src1_tag));
  assign in2_ready = disp_src2_ready || (cdb_en && (cdb_tag == disp_src2_tag));

  // Younger than the rollback point, ages taken modulo ROB size
  assign tail_dist  = rob_tail_idx - rollback_idx;
  assign entry_dist = entry_rob_idx - rollback_idx;
  assign squash     = busy && rollback_en && (tail_dist >= entry_dist);

  assign req       = busy && src1_ok && src2_ok && !squash;
  assign take      = req && grant;
  assign free_next = !busy || take || squash;

  always_ff @(posedge clock) begin
    if (reset) begin
      busy       <= 1'b0;
      src1_ready <= 1'b0;
      src2_ready <= 1'b0;
    end else if (en) begin
      if (load) begin
        busy       <= 1'b1;
        src1_ready <= in1_ready;
        src2_ready <= in2_ready;
      end else if (take || squash) begin
        busy <= 1'b0; // Handed over or killed
      end else begin
        src1_ready <= src1_ok; // Keep CDB wakeups
        src2_ready <= src2_ok;
      end
    end
  end

  // Payload, only meaningful while busy
  always_ff @(posedge clock) begin
    if (en && load) begin
      entry_inst     <= disp_inst;
      entry_rob_idx  <= disp_rob_idx;
      entry_dest_tag <= disp_dest_tag;
      entry_src1_tag <= disp_src1_tag;
      entry_src2_tag <= disp_src2_tag;
    end
  end

endmodule

`default_nettype wire

// File: src/rs_issue_regs.sv
`default_nettype none

module rs_issue_regs #(
  parameter int NUM_FU    = core_cfg_pkg::NUM_FU,
  parameter int ROB_IDX_W = core_cfg_pkg::ROB_IDX_W,
  parameter int TAG_W     = core_cfg_pkg::TAG_W
) (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic                                         en,
  input  logic [NUM_FU-1:0]                            slot_req,
  input  logic [NUM_FU-1:0][core_cfg_pkg::INST_W-1:0]  slot_inst,
  input  logic [NUM_FU-1:0][ROB_IDX_W-1:0]             slot_rob_idx,
  input  logic [NUM_FU-1:0][TAG_W-1:0]                 slot_dest_tag,
  input  logic [NUM_FU-1:0][TAG_W-1:0]                 slot_src1_tag,
  input  logic [NUM_FU-1:0][TAG_W-1:0]                 slot_src2_tag,
  input  logic [NUM_FU-1:0]                            fu_ready,
  input  logic                                         rollback_en,
  input  logic [ROB_IDX_W-1:0]                         rollback_idx,
  input  logic [ROB_IDX_W-1:0]                         rob_tail_idx,
  output logic [NUM_FU-1:0]                            slot_grant,
  output logic [NUM_FU-1:0]                            issue_valid,
  output logic [NUM_FU-1:0][core_cfg_pkg::INST_W-1:0]  issue_inst,
  output logic [NUM_FU-1:0][ROB_IDX_W-1:0]             issue_rob_idx,
  output logic [NUM_FU-1:0][TAG_W-1:0]                 issue_dest_tag,
  output logic [NUM_FU-1:0][TAG_W-1:0]                 issue_src1_tag,
  output logic [NUM_FU-1:0][TAG_W-1:0]                 issue_src2_tag
);

  logic [ROB_IDX_W-1:0]             tail_dist;
  logic [NUM_FU-1:0][ROB_IDX_W-1:0] reg_dist;
  logic [NUM_FU-1:0]                reg_squash; // Held entry is younger than rollback
  logic [NUM_FU-1:0]                load;

  assign tail_dist = rob_tail_idx - rollback_idx;

  always_comb begin
    for (int i = 0; i < NUM_FU; i++) begin
      reg_dist[i]   = issue_rob_idx[i] - rollback_idx;
      reg_squash[i] = issue_valid[i] && rollback_en && (tail_dist >= reg_dist[i]);
      // Room by next edge: empty, drained or killed
      slot_grant[i] = en && (!issue_valid[i] || fu_ready[i] || reg_squash[i]);
      load[i]       = slot_req[i] && slot_grant[i];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      issue_valid <= '0;
    end else if (en) begin
      for (int i = 0; i < NUM_FU; i++) begin
        if (load[i]) begin
          issue_valid[i] <= 1'b1;
        end else if (fu_ready[i] || reg_squash[i]) begin
          issue_valid[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < NUM_FU; i++) begin
      if (en && load[i]) begin
        issue_inst[i]     <= slot_inst[i];
        issue_rob_idx[i]  <= slot_rob_idx[i];
        issue_dest_tag[i] <= slot_dest_tag[i];
        issue_src1_tag[i] <= slot_src1_tag[i];
        issue_src2_tag[i] <= slot_src2_tag[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: src/rs_top.sv
`default_nettype none

module rs_top #(
  parameter int                          NUM_FU    = core_cfg_pkg::NUM_FU,
  parameter int                          ROB_IDX_W = core_cfg_pkg::ROB_IDX_W,
  parameter int                          TAG_W     = core_cfg_pkg::TAG_W,
  parameter rs_types_pkg::fu_kind_list_t FU_KINDS  = rs_types_pkg::FU_KINDS_DEFAULT
) (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic                                         en,
  input  logic                                         dispatch_en,
  input  rs_types_pkg::fu_kind_t                       disp_kind,
  input  logic [core_cfg_pkg::INST_W-1:0]              disp_inst,
  input  logic [ROB_IDX_W-1:0]                         disp_rob_idx,
  input  logic [TAG_W-1:0]                             disp_dest_tag,
  input  logic [TAG_W-1:0]                             disp_src1_tag,
  input  logic                                         disp_src1_ready,
  input  logic [TAG_W-1:0]                             disp_src2_tag,
  input  logic                                         disp_src2_ready,
  input  logic                                         cdb_en,
  input  logic [TAG_W-1:0]                             cdb_tag,
  input  logic                                         rollback_en,
  input  logic [ROB_IDX_W-1:0]                         rollback_idx,
  input  logic [ROB_IDX_W-1:0]                         rob_tail_idx,
  input  logic [NUM_FU-1:0]                            fu_ready,
  output logic                                         disp_accept,
  output logic [NUM_FU-1:0]                            issue_valid,
  output logic [NUM_FU-1:0][core_cfg_pkg::INST_W-1:0]  issue_inst,
  output logic [NUM_FU-1:0][ROB_IDX_W-1:0]             issue_rob_idx,
  output logic [NUM_FU-1:0][TAG_W-1:0]                 issue_dest_tag,
  output logic [NUM_FU-1:0][TAG_W-1:0]                 issue_src1_tag,
  output logic [NUM_FU-1:0][TAG_W-1:0]                 issue_src2_tag
);

  import core_cfg_pkg::*;

  logic [NUM_FU-1:0]              slot_write;     // One-hot from the allocator
  logic [NUM_FU-1:0]              slot_free_next;
  logic [NUM_FU-1:0]              slot_req;
  logic [NUM_FU-1:0]              slot_grant;
  logic [NUM_FU-1:0][INST_W-1:0]  slot_inst;
  logic [NUM_FU-1:0][ROB_IDX_W-1:0] slot_rob_idx;
  logic [NUM_FU-1:0][TAG_W-1:0]   slot_dest_tag;
  logic [NUM_FU-1:0][TAG_W-1:0]   slot_src1_tag;
  logic [NUM_FU-1:0][TAG_W-1:0]   slot_src2_tag;

  rs_dispatch_alloc #(
    .NUM_FU   (NUM_FU),
    .FU_KINDS (FU_KINDS)
  ) u_alloc (
    .en             (en),
    .dispatch_en    (dispatch_en),
    .rollback_en    (rollback_en),
    .disp_kind      (disp_kind),
    .slot_free_next (slot_free_next),
    .slot_write     (slot_write),
    .disp_accept    (disp_accept)
  );

  // One slot per FU, each bound to its kind
  for (genvar g = 0; g < NUM_FU; g++) begin : g_slot
    rs_slot #(
      .KIND      (FU_KINDS[g]),
      .ROB_IDX_W (ROB_IDX_W),
      .TAG_W     (TAG_W)
    ) u_slot (
      .clock           (clock),
      .reset           (reset),
      .en              (en),
      .write           (slot_write[g]),
      .disp_kind       (disp_kind),
      .disp_inst       (disp_inst),
      .disp_rob_idx    (disp_rob_idx),
      .disp_dest_tag   (disp_dest_tag),
      .disp_src1_tag   (disp_src1_tag),
      .disp_src1_ready (disp_src1_ready),
      .disp_src2_tag   (disp_src2_tag),
      .disp_src2_ready (disp_src2_ready),
      .cdb_en          (cdb_en),
      .cdb_tag         (cdb_tag),
      .rollback_en     (rollback_en),
      .rollback_idx    (rollback_idx),
      .rob_tail_idx    (rob_tail_idx),
      .grant           (slot_grant[g]),
      .req             (slot_req[g]),
      .free_next       (slot_free_next[g]),
      .entry_inst      (slot_inst[g]),
      .entry_rob_idx   (slot_rob_idx[g]),
      .entry_dest_tag  (slot_dest_tag[g]),
      .entry_src1_tag  (slot_src1_tag[g]),
      .entry_src2_tag  (slot_src2_tag[g])
    );
  end

  rs_issue_regs #(
    .NUM_FU    (NUM_FU),
    .ROB_IDX_W (ROB_IDX_W),
    .TAG_W     (TAG_W)
  ) u_issue (
    .clock          (clock),
    .reset          (reset),
    .en             (en),
    .slot_req       (slot_req),
    .slot_inst      (slot_inst),
    .slot_rob_idx   (slot_rob_idx),
    .slot_dest_tag  (slot_dest_tag),
    .slot_src1_tag  (slot_src1_tag),
    .slot_src2_tag  (slot_src2_tag),
    .fu_ready       (fu_ready),
    .rollback_en    (rollback_en),
    .rollback_idx   (rollback_idx),
    .rob_tail_idx   (rob_tail_idx),
    .slot_grant     (slot_grant),
    .issue_valid    (issue_valid),
    .issue_inst     (issue_inst),
    .issue_rob_idx  (issue_rob_idx),
    .issue_dest_tag (issue_dest_tag),
    .issue_src1_tag (issue_src1_tag),
    .issue_src2_tag (issue_src2_tag)
  );

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 4
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  // Synchronous reset, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// File: verif/rs_assertions.sv
`default_nettype none

module rs_assertions #(
  parameter int NUM_FU    = core_cfg_pkg::NUM_FU,
  parameter int ROB_IDX_W = core_cfg_pkg::ROB_IDX_W
) (
  input logic                             clock,
  input logic                             reset,
  input logic                             rollback_en,
  input logic                             disp_accept,
  input logic [NUM_FU-1:0]                fu_ready,
  input logic [NUM_FU-1:0]                issue_valid,
  input logic [NUM_FU-1:0][ROB_IDX_W-1:0] issue_rob_idx
);

  int fail_count = 0; // Assertion failures so far

  a_no_accept_in_rollback: assert property (
    @(posedge clock) disable iff (reset) !(disp_accept && rollback_en)
  ) else begin
    fail_count++;
    $error("disp_accept high while rollback_en is high");
  end

  // Stalled output register keeps its entry
  for (genvar i = 0; i < NUM_FU; i++) begin : g_hold
    a_hold_under_stall: assert property (
      @(posedge clock) disable iff (reset)
      (issue_valid[i] && !fu_ready[i] && !rollback_en)
        |=> (issue_valid[i] && $stable(issue_rob_idx[i]))
    ) else begin
      fail_count++;
      $error("Issue register %0d changed while fu_ready was low", i);
    end
  end

  a_empty_after_reset: assert property (
    @(posedge clock) reset |=> (issue_valid == '0)
  ) else begin
    fail_count++;
    $error("issue_valid not cleared after reset");
  end

endmodule

bind rs_top rs_assertions #(
  .NUM_FU    (NUM_FU),
  .ROB_IDX_W (ROB_IDX_W)
) u_assertions (
  .clock         (clock),
  .reset         (reset),
  .rollback_en   (rollback_en),
  .disp_accept   (disp_accept),
  .fu_ready      (fu_ready),
  .issue_valid   (issue_valid),
  .issue_rob_idx (issue_rob_idx)
);

`default_nettype wire

// File: verif/rs_tb.sv
`default_nettype none

module rs_tb;

  import core_cfg_pkg::*;
  import rs_types_pkg::*;

  localparam int ISSUE_TIMEOUT = 20; // Cycles
  localparam int RESET_TIMEOUT = 20;

  typedef struct packed {
    logic [INST_W-1:0]    inst;
    logic [ROB_IDX_W-1:0] rob;
    logic [TAG_W-1:0]     dest;
    logic [TAG_W-1:0]     src1;
    logic [TAG_W-1:0]     src2;
  } entry_t;

  logic                               clock;
  logic                               reset;
  logic                               en;
  logic                               dispatch_en;
  fu_kind_t                           disp_kind;
  logic [INST_W-1:0]                  disp_inst;
  logic [ROB_IDX_W-1:0]               disp_rob_idx;
  logic [TAG_W-1:0]                   disp_dest_tag;
  logic [TAG_W-1:0]                   disp_src1_tag;
  logic                               disp_src1_ready;
  logic [TAG_W-1:0]                   disp_src2_tag;
  logic                               disp_src2_ready;
  logic                               cdb_en;
  logic [TAG_W-1:0]                   cdb_tag;
  logic                               rollback_en;
  logic [ROB_IDX_W-1:0]               rollback_idx;
  logic [ROB_IDX_W-1:0]               rob_tail_idx;
  logic [NUM_FU-1:0]                  fu_ready;
  logic                               disp_accept;
  logic [NUM_FU-1:0]                  issue_valid;
  logic [NUM_FU-1:0][INST_W-1:0]      issue_inst;
  logic [NUM_FU-1:0][ROB_IDX_W-1:0]   issue_rob_idx;
  logic [NUM_FU-1:0][TAG_W-1:0]       issue_dest_tag;
  logic [NUM_FU-1:0][TAG_W-1:0]       issue_src1_tag;
  logic [NUM_FU-1:0][TAG_W-1:0]       issue_src2_tag;

  entry_t model_q[NUM_FU][$]; // Per FU, register entry first, then slot
  int     error_count = 0;

  tb_clock_gen #(.PERIOD(8), .RESET_CYCLES(4)) u_clock (.clock(clock), .reset(reset));

  rs_top u_dut (.*);

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      error_count++;
      abort_run($sformatf("Fail at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp));
    end
  endtask

  function automatic entry_t make_entry(input logic [ROB_IDX_W-1:0] rob);
    entry_t e;
    e.inst = $urandom;
    e.rob  = rob;
    e.dest = TAG_W'($urandom);
    e.src1 = TAG_W'($urandom);
    e.src2 = TAG_W'($urandom);
    return e;
  endfunction

  // Age test against the rollback point, modulo ROB size
  function automatic logic in_squash_window(input logic [ROB_IDX_W-1:0] rob,
                                            input logic [ROB_IDX_W-1:0] rb,
                                            input logic [ROB_IDX_W-1:0] tail);
    logic [ROB_IDX_W-1:0] window;
    logic [ROB_IDX_W-1:0] age;
    window = tail - rb;
    age    = rob - rb;
    return age <= window;
  endfunction

  // Called right after a falling edge, returns at the next one
  task automatic send(input fu_kind_t kind, input entry_t e, input logic r1, input logic r2,
                      input logic exp_acc, input int fu);
    dispatch_en     = 1'b1;
    disp_kind       = kind;
    disp_inst       = e.inst;
    disp_rob_idx    = e.rob;
    disp_dest_tag   = e.dest;
    disp_src1_tag   = e.src1;
    disp_src1_ready = r1;
    disp_src2_tag   = e.src2;
    disp_src2_ready = r2;
    #1;
    check("disp_accept", disp_accept, exp_acc);
    @(negedge clock);
    dispatch_en = 1'b0;
    if (exp_acc) model_q[fu].push_back(e);
  endtask

  task automatic wait_issue(input int fu, output int cycles);
    cycles = 0;
    while (!issue_valid[fu]) begin
      if (cycles == ISSUE_TIMEOUT) begin
        abort_run($sformatf("Timeout waiting for issue_valid on FU %0d", fu));
      end else begin
        @(negedge clock);
        cycles++;
      end
    end
  endtask

  task automatic broadcast(input logic [TAG_W-1:0] tag);
    cdb_en  = 1'b1;
    cdb_tag = tag;
    @(negedge clock);
    cdb_en = 1'b0;
  endtask

  task automatic check_fu(input int fu);
    check($sformatf("issue_valid[%0d]", fu), issue_valid[fu], model_q[fu].size() != 0);
    if (model_q[fu].size() != 0) begin
      check($sformatf("issue_inst[%0d]", fu), issue_inst[fu], model_q[fu][0].inst);
      check($sformatf("issue_rob_idx[%0d]", fu), issue_rob_idx[fu], model_q[fu][0].rob);
      check($sformatf("issue_dest_tag[%0d]", fu), issue_dest_tag[fu], model_q[fu][0].dest);
      check($sformatf("issue_src1_tag[%0d]", fu), issue_src1_tag[fu], model_q[fu][0].src1);
      check($sformatf("issue_src2_tag[%0d]", fu), issue_src2_tag[fu], model_q[fu][0].src2);
    end
  endtask

  task automatic check_all();
    for (int fu = 0; fu < NUM_FU; fu++) check_fu(fu);
  endtask

  // One cycle of fu_ready, next entry moves up
  task automatic drain(input int fu);
    fu_ready[fu] = 1'b1;
    @(negedge clock);
    fu_ready[fu] = 1'b0;
    void'(model_q[fu].pop_front());
  endtask

  task automatic drain_all();
    for (int fu = 0; fu < NUM_FU; fu++) begin
      while (model_q[fu].size() != 0) begin
        drain(fu);
        check_fu(fu);
      end
    end
  endtask

  task automatic apply_rollback(input logic [ROB_IDX_W-1:0] rb,
                                input logic [ROB_IDX_W-1:0] tail);
    for (int fu = 0; fu < NUM_FU; fu++) begin
      for (int k = model_q[fu].size() - 1; k >= 0; k--) begin
        if (in_squash_window(model_q[fu][k].rob, rb, tail)) model_q[fu].delete(k);
      end
    end
  endtask

  task automatic test_ready_dispatch();
    int n;
    send(FU_ALU, make_entry(ROB_IDX_W'($urandom)), 1'b1, 1'b1, 1'b1, 0);
    wait_issue(0, n);
    check("dispatch to issue cycles", n, 1);
    check_fu(0);
    send(FU_ALU, make_entry(ROB_IDX_W'($urandom)), 1'b1, 1'b1, 1'b1, 0);
    send(FU_ALU, make_entry(ROB_IDX_W'($urandom)), 1'b1, 1'b1, 1'b1, 1); // Slot 0 stays busy
    wait_issue(1, n);
    check_all();
    drain_all();
  endtask

  task automatic test_wakeup();
    entry_t d;
    entry_t e;
    int     n;
    d      = make_entry(ROB_IDX_W'($urandom));
    d.src2 = d.src1 + 1'b1;
    send(FU_ALU, d, 1'b0, 1'b0, 1'b1, 0);
    repeat (3) begin
      check("issue_valid[0] before wakeup", issue_valid[0], 1'b0);
      @(negedge clock);
    end
    broadcast(d.src1);
    check("issue_valid[0] with one source", issue_valid[0], 1'b0);
    broadcast(d.src2);
    wait_issue(0, n);
    check("wakeup to issue cycles", n, 0);
    check_fu(0);
    drain_all();
    // Broadcast during the dispatch cycle
    e       = make_entry(ROB_IDX_W'($urandom));
    cdb_en  = 1'b1;
    cdb_tag = e.src1;
    send(FU_ALU, e, 1'b0, 1'b1, 1'b1, 0);
    cdb_en = 1'b0;
    wait_issue(0, n);
    check_fu(0);
    drain_all();
  endtask

  task automatic test_back_pressure();
    int n;
    send(FU_MULT, make_entry(ROB_IDX_W'($urandom)), 1'b1, 1'b1, 1'b1, 2);
    wait_issue(2, n);
    send(FU_MULT, make_entry(ROB_IDX_W'($urandom)), 1'b1, 1'b1, 1'b1, 2);
    send(FU_MULT, make_entry(ROB_IDX_W'($urandom)), 1'b1, 1'b1, 1'b0, 2); // Both stages full
    check_fu(2);
    // Retry while the register drains, slot frees in the same cycle
    fu_ready[2] = 1'b1;
    send(FU_MULT, make_entry(ROB_IDX_W'($urandom)), 1'b1, 1'b1, 1'b1, 2);
    fu_ready[2] = 1'b0;
    void'(model_q[2].pop_front());
    check_fu(2);
    drain_all();
  endtask

  task automatic test_kind_routing();
    int n;
    send(FU_BRANCH, make_entry(ROB_IDX_W'($urandom)), 1'b1, 1'b1, 1'b0, 0); // No branch FU
    send(FU_MEM, make_entry(ROB_IDX_W'($urandom)), 1'b1, 1'b1, 1'b1, 3);
    wait_issue(3, n);
    check_all();
    drain_all();
  endtask

  task automatic test_rollback();
    logic [ROB_IDX_W-1:0] rb;
    logic [ROB_IDX_W-1:0] tail;
    int                   n;
    rb   = ROB_IDX_W'(13 + ($urandom % 3));
    tail = rb + 3'd3; // Wraps past zero
    send(FU_ALU, make_entry(rb - 2'd2), 1'b1, 1'b1, 1'b1, 0);
    send(FU_ALU, make_entry(rb + 1'b1), 1'b1, 1'b1, 1'b1, 0);
    send(FU_ALU, make_entry(rb), 1'b1, 1'b1, 1'b1, 1);
    send(FU_ALU, make_entry(rb + 3'd5), 1'b1, 1'b1, 1'b1, 1);
    send(FU_MULT, make_entry(rb + 2'd2), 1'b1, 1'b1, 1'b1, 2);
    send(FU_MEM, make_entry(rb - 1'b1), 1'b1, 1'b1, 1'b1, 3);
    wait_issue(3, n);
    check_all();
    rollback_en  = 1'b1;
    rollback_idx = rb;
    rob_tail_idx = tail;
    send(FU_MULT, make_entry(rb), 1'b1, 1'b1, 1'b0, 2); // Slot 2 free but refused
    rollback_en = 1'b0;
    apply_rollback(rb, tail);
    check_all();
    drain_all();
  endtask

  task automatic test_hold();
    int n;
    send(FU_ALU, make_entry(ROB_IDX_W'($urandom)), 1'b1, 1'b1, 1'b1, 0);
    wait_issue(0, n);
    en       = 1'b0;
    fu_ready = '1;
    repeat (4) begin
      cdb_en  = 1'b1;
      cdb_tag = TAG_W'($urandom);
      send(FU_ALU, make_entry(ROB_IDX_W'($urandom)), 1'b1, 1'b1, 1'b0, 0);
      check_all(); // Nothing drains or loads
    end
    cdb_en   = 1'b0;
    fu_ready = '0;
    en       = 1'b1;
    check_all();
    send(FU_ALU, make_entry(ROB_IDX_W'($urandom)), 1'b1, 1'b1, 1'b1, 0);
    check_all();
    drain_all();
  endtask

  initial begin
    int waited;
    void'($urandom(32'h112d_b76d));
    en              = 1'b1;
    dispatch_en     = 1'b0;
    disp_kind       = FU_ALU;
    disp_inst       = '0;
    disp_rob_idx    = '0;
    disp_dest_tag   = '0;
    disp_src1_tag   = '0;
    disp_src1_ready = 1'b0;
    disp_src2_tag   = '0;
    disp_src2_ready = 1'b0;
    cdb_en          = 1'b0;
    cdb_tag         = '0;
    rollback_en     = 1'b0;
    rollback_idx    = '0;
    rob_tail_idx    = '0;
    fu_ready        = '0; // FUs stall unless a test drains them
    waited          = 0;
    @(negedge clock);
    while (reset) begin
      if (waited == RESET_TIMEOUT) begin
        abort_run("Reset was never released");
      end else begin
        @(negedge clock);
        waited++;
      end
    end
    check("issue_valid after reset", issue_valid, '0);
    test_ready_dispatch();
    test_wakeup();
    test_back_pressure();
    test_kind_routing();
    test_rollback();
    test_hold();
    if (error_count == 0 && u_dut.u_assertions.fail_count == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      abort_run("Errors were recorded during the run");
    end
  end

endmodule

`default_nettype wire

// File: sim.f
src/core_cfg_pkg.sv
src/rs_types_pkg.sv
src/rs_dispatch_alloc.sv
src/rs_slot.sv
src/rs_issue_regs.sv
src/rs_top.sv
verif/tb_clock_gen.sv
verif/rs_assertions.sv
verif/rs_tb.sv

// File: Makefile
SRCS := $(wildcard src/*.sv verif/*.sv)

all: run

obj_dir/Vrs_tb: sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module rs_tb -f sim.f

run: obj_dir/Vrs_tb
	./obj_dir/Vrs_tb | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
